// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_pau_top
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src/pau_convert.sv ====
// #########################################################################
// Posit32 <-> signed 32-bit integer conversion, round to nearest even.
// P2I saturates and maps NaR to the most negative integer. Each result
// register only loads while its own operation is issued.
// #########################################################################

`timescale 1ns/10ps
`default_nettype none

module pau_convert import posit_pkg::*, pau_op_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  pau_op_e op_i,
    input  xlen_t   operand_a_i,
    output int32_t  p2i_o,
    output posit_t  i2p_o
);

    localparam int32_t INT_MAX = 32'sh7fff_ffff;
    localparam int32_t INT_MIN = 32'sh8000_0000;

    // Posit to integer
    posit_t                     p_in;
    logic                       p_sign;
    posit_t                     p_abs;
    logic [POSLEN-2:0]          p_body;     // Everything after the sign
    logic                       r0;         // Regime polarity
    logic [5:0]                 run;        // Regime run length
    logic                       run_done;
    logic [POSLEN-2:0]          p_rem;      // Exponent and fraction, left aligned
    logic [POS_ES-1:0]          p_exp;
    logic [POSLEN-POS_ES-2:0]   p_frac;
    logic signed [6:0]          k_p;
    logic signed [8:0]          p_scale;    // 4k + exp
    logic [5:0]                 p_shamt;
    logic [63:0]                p_fix;
    logic [63:0]                p_sh;
    logic [31:0]                p_int;
    logic                       p_guard;
    logic                       p_sticky;
    logic [32:0]                p_mag;
    int32_t                     p2i_d;

    // Integer to posit
    int32_t                     i_in;
    logic                       i_sign;
    logic [31:0]                i_mag;
    logic [4:0]                 i_msb;      // Leading one position
    logic [31:0]                i_norm;
    logic [63:0]                i_base;
    logic [63:0]                i_shv;
    logic [POSLEN-2:0]          i_body;
    logic                       i_guard;
    logic                       i_sticky;
    logic [POSLEN-2:0]          i_round;
    posit_t                     i2p_d;

    assign p_in   = operand_a_i[POSLEN-1:0];
    assign p_sign = p_in[POSLEN-1];
    assign p_abs  = p_sign ? (~p_in + posit_t'(1)) : p_in;
    assign p_body = p_abs[POSLEN-2:0];
    assign r0     = p_body[POSLEN-2];

    always_comb begin : p_regime
        run      = '0;
        run_done = 1'b0;
        for (int i = POSLEN - 2; i >= 0; i--) begin
            if (!run_done && (p_body[i] == r0)) begin
                run = run + 6'd1;
            end else begin
                run_done = 1'b1;
            end
        end
    end

    assign p_rem  = p_body << (run + 6'd1); // Drop regime and its terminator
    assign p_exp  = p_rem[POSLEN-2 -: POS_ES];
    assign p_frac = p_rem[POSLEN-POS_ES-2:0];
    assign k_p    = r0 ? ($signed({1'b0, run}) - 7'sd1) : -$signed({1'b0, run});
    assign p_scale = $signed({k_p, p_exp});

    // Hidden one at bit 31 stands for 2^-1, integer part lands in [63:32]
    assign p_fix   = {32'b0, 1'b1, p_frac, 2'b0};
    assign p_shamt = p_scale[5:0] + 6'd1;   // Only used for scale -1..30
    assign p_sh    = p_fix << p_shamt;
    assign p_int    = p_sh[63:32];
    assign p_guard  = p_sh[31];
    assign p_sticky = |p_sh[30:0];
    assign p_mag    = {1'b0, p_int} + 33'(p_guard & (p_sticky | p_int[0]));

    always_comb begin : p2i_sel
        if (p_in == '0) begin
            p2i_d = '0;
        end else if (p_in == POSIT_NAR) begin
            p2i_d = INT_MIN;
        end else if (p_scale < -9'sd1) begin
            p2i_d = '0;                      // Below one half rounds to zero
        end else if ((p_scale > 9'sd30) || (p_mag > 33'h0_7fff_ffff)) begin
            p2i_d = p_sign ? INT_MIN : INT_MAX;
        end else begin
            p2i_d = p_sign ? -int32_t'(p_mag[31:0]) : int32_t'(p_mag[31:0]);
        end
    end

    assign i_in   = operand_a_i[31:0];
    assign i_sign = i_in[31];
    assign i_mag  = i_sign ? (~i_in + 32'd1) : i_in; // Most negative stays 2^31

    always_comb begin : i_lead_one
        i_msb = '0;
        for (int i = 0; i < 32; i++) begin
            if (i_mag[i]) begin
                i_msb = 5'(i);
            end
        end
    end

    assign i_norm = i_mag << (5'd31 - i_msb);

    // Regime for k = 0 is "10", arithmetic shift by k adds the extra ones
    assign i_base   = {2'b10, i_msb[POS_ES-1:0], i_norm[30:0], 29'b0};
    assign i_shv    = $signed(i_base) >>> i_msb[4:POS_ES];
    assign i_body   = i_shv[63:33];
    assign i_guard  = i_shv[32];
    assign i_sticky = |i_shv[31:0];
    assign i_round  = i_body + (POSLEN-1)'(i_guard & (i_sticky | i_body[0]));

    always_comb begin : i2p_sel
        if (i_in == '0) begin
            i2p_d = '0;
        end else if (i_sign) begin
            i2p_d = ~{1'b0, i_round} + posit_t'(1);
        end else begin
            i2p_d = {1'b0, i_round};
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : conv_regs
        if (!rst_ni) begin
            p2i_o <= '0;
            i2p_o <= '0;
        end else begin
            if (op_i == PCVT_P2I) begin
                p2i_o <= p2i_d;
            end
            if (op_i == PCVT_I2P) begin
                i2p_o <= i2p_d;
            end
        end
    end

    a_run_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (op_i == PCVT_P2I) |-> (run <= 6'(POSLEN - 1)))
        else $error("regime run longer than the posit body");

endmodule

`default_nettype wire

// ==== src/pau_op_pkg.sv ====
// #########################################################################
// Operation codes and datapath width of the posit arithmetic unit.
// Shared by the top level, the execution units and the result stage.
// #########################################################################

`default_nettype none

package pau_op_pkg;

    localparam int unsigned XLEN = 64; // Integer register width

    typedef logic [XLEN-1:0] xlen_t;

    // Operations kept in the unit, all single cycle
    typedef enum logic [2:0] {
        PSGNJ    = 3'd0, // Sign of b
        PSGNJN   = 3'd1, // Inverted sign of b
        PSGNJX   = 3'd2, // Sign of a xor sign of b
        PMV_P2X  = 3'd3, // Posit register to integer register
        PMV_X2P  = 3'd4, // Integer register to posit register
        PCVT_P2I = 3'd5, // Posit to signed 32-bit integer
        PCVT_I2P = 3'd6  // Signed 32-bit integer to posit
    } pau_op_e;

endpackage

`default_nettype wire

// ==== src/pau_result.sv ====
// #########################################################################
// Result stage of the posit unit. Delays operation, valid and id by one
// register, then picks the matching unit result and extends it to XLEN.
// #########################################################################

`timescale 1ns/10ps
`default_nettype none

module pau_result import posit_pkg::*, pau_op_pkg::*; #(
    parameter int unsigned TRANS_ID_BITS = 3
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     valid_i,
    input  pau_op_e                  op_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    input  posit_t                   sgnj_i,
    input  xlen_t                    move_i,
    input  int32_t                   p2i_i,
    input  posit_t                   i2p_i,
    output logic                     valid_o,
    output logic [TRANS_ID_BITS-1:0] trans_id_o,
    output xlen_t                    result_o
);

    localparam int unsigned INT_W = $bits(int32_t);

    pau_op_e op_q;
    logic    valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin : issue_regs
        if (!rst_ni) begin
            valid_q    <= 1'b0;
            op_q       <= PSGNJ;
            trans_id_o <= '0;
        end else begin
            valid_q    <= valid_i;
            op_q       <= op_i;
            trans_id_o <= trans_id_i;
        end
    end

    assign valid_o = valid_q;

    always_comb begin : result_mux
        result_o = '0;
        if (valid_q) begin
            unique case (op_q)
                PSGNJ,
                PSGNJN,
                PSGNJX:   result_o = {{(XLEN-POSLEN){1'b0}}, sgnj_i};
                PCVT_I2P: result_o = {{(XLEN-POSLEN){1'b0}}, i2p_i};
                PCVT_P2I: result_o = {{(XLEN-INT_W){p2i_i[INT_W-1]}}, p2i_i};
                PMV_P2X,
                PMV_X2P:  result_o = {{(XLEN-32){move_i[31]}}, move_i[31:0]};
                default:  result_o = '0;
            endcase
        end
    end

    // Back-to-back results need back-to-back issues
    a_valid_pairs : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_o && $past(valid_o)) |-> ($past(valid_i) && $past(valid_i, 2)))
        else $error("valid_o held without a matching issue");

endmodule

`default_nettype wire

// ==== src/pau_sign_move.sv ====
// #########################################################################
// Sign injection and register moves of the posit unit. Both results are
// registered every cycle and picked up by the result stage one cycle later.
// #########################################################################

`timescale 1ns/10ps
`default_nettype none

module pau_sign_move import posit_pkg::*, pau_op_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  pau_op_e op_i,
    input  xlen_t   operand_a_i,
    input  xlen_t   operand_b_i,
    output posit_t  sgnj_o,
    output xlen_t   move_o
);

    posit_t pos_a;
    posit_t sgnj_d;
    xlen_t  move_d;
    logic   sign_a;
    logic   sign_b;
    logic   flip;    // Result needs the opposite sign of a

    assign pos_a  = operand_a_i[POSLEN-1:0];
    assign sign_a = pos_a[POSLEN-1];
    assign sign_b = operand_b_i[POSLEN-1];

    always_comb begin : flip_dec
        flip   = 1'b0;
        move_d = '0;
        unique case (op_i)
            PSGNJ:   flip = (sign_a != sign_b);
            PSGNJN:  flip = (sign_a == sign_b);
            PSGNJX:  flip = sign_b; // a ^ b differs from a exactly when b is set
            PMV_P2X,
            PMV_X2P: move_d = operand_a_i;
            default: ;
        endcase
    end

    // Posit negation is plain two's complement of the whole word
    assign sgnj_d = flip ? (~pos_a + posit_t'(1)) : pos_a;

    always_ff @(posedge clk_i or negedge rst_ni) begin : sgnj_regs
        if (!rst_ni) begin
            sgnj_o <= '0;
            move_o <= '0;
        end else begin
            sgnj_o <= sgnj_d;
            move_o <= move_d;
        end
    end

    a_flip_only_sgnj : assert property (@(posedge clk_i) disable iff (!rst_ni)
        flip |-> (op_i inside {PSGNJ, PSGNJN, PSGNJX}))
        else $error("sign flip raised outside sign injection");

endmodule

`default_nettype wire

// ==== src/pau_top.sv ====
// #########################################################################
// Posit arithmetic unit top level for a 64-bit datapath. Every operation
// returns one cycle after issue with its id, new work each cycle.
// #########################################################################

`timescale 1ns/10ps
`default_nettype none

module pau_top import posit_pkg::*, pau_op_pkg::*; #(
    parameter int unsigned TRANS_ID_BITS = 3
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     valid_i,
    input  pau_op_e                  op_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    input  xlen_t                    operand_a_i,
    input  xlen_t                    operand_b_i,
    output logic                     valid_o,
    output logic [TRANS_ID_BITS-1:0] trans_id_o,
    output xlen_t                    result_o
);

    posit_t sgnj;   // Registered unit results
    xlen_t  move;
    int32_t p2i;
    posit_t i2p;

    pau_sign_move sign_move_inst (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .op_i        ( op_i        ),
        .operand_a_i ( operand_a_i ),
        .operand_b_i ( operand_b_i ),
        .sgnj_o      ( sgnj        ),
        .move_o      ( move        )
    );

    pau_convert convert_inst (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .op_i        ( op_i        ),
        .operand_a_i ( operand_a_i ),
        .p2i_o       ( p2i         ),
        .i2p_o       ( i2p         )
    );

    pau_result #(
        .TRANS_ID_BITS ( TRANS_ID_BITS )
    ) result_inst (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .valid_i    ( valid_i    ),
        .op_i       ( op_i       ),
        .trans_id_i ( trans_id_i ),
        .sgnj_i     ( sgnj       ),
        .move_i     ( move       ),
        .p2i_i      ( p2i        ),
        .i2p_i      ( i2p        ),
        .valid_o    ( valid_o    ),
        .trans_id_o ( trans_id_o ),
        .result_o   ( result_o   )
    );

endmodule

`default_nettype wire

// ==== src/posit_pkg.sv ====
// #########################################################################
// Posit32 format description with two exponent bits. Imported by the
// sign-injection and conversion logic of the posit arithmetic unit.
// #########################################################################

`default_nettype none

package posit_pkg;

    // Format of the supported posit
    localparam int unsigned POSLEN = 32; // Total posit width
    localparam int unsigned POS_ES = 2;  // Exponent field width

    // One posit value as it sits in a register
    typedef logic [POSLEN-1:0] posit_t;

    // Not-a-Real: only the sign bit is set
    localparam posit_t POSIT_NAR = {1'b1, {(POSLEN-1){1'b0}}};

    // Signed 32-bit integer, source of I2P and result of P2I
    typedef logic signed [31:0] int32_t;

endpackage

`default_nettype wire

// ==== testbench/tb_pau_top.sv ====
// ##########################################################################
// Self-checking testbench for the posit arithmetic unit. A table of
// operations with hand-computed results is applied once with idle gaps
// and once back to back, checking result, id and one-cycle latency.
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module tb_pau_top import pau_op_pkg::*;
;

    localparam int unsigned TID_W   = 3;
    localparam int          TIMEOUT = 20; // Cycles to wait for valid_o

    // Sign injection operands where b only contributes bit 31
    localparam xlen_t A_POS = 64'hA5A5_A5A5_4C00_0000; // Posit 3.0 with junk above
    localparam xlen_t A_NEG = 64'h0000_0000_B400_0000; // Posit -3.0
    localparam xlen_t B_POS = 64'hFFFF_FFFF_1234_5678;
    localparam xlen_t B_NEG = 64'h0000_0000_8765_4321;
    localparam xlen_t R_POS = 64'h0000_0000_4C00_0000;
    localparam xlen_t R_NEG = 64'h0000_0000_B400_0000;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   valid_i;
    pau_op_e                op_i;
    logic [TID_W-1:0]       trans_id_i;
    xlen_t                  operand_a_i;
    xlen_t                  operand_b_i;
    logic                   valid_o;
    logic [TID_W-1:0]       trans_id_o;
    xlen_t                  result_o;

    // Stimulus table, one entry per row in every queue
    string                  row_name[$];
    pau_op_e                row_op[$];
    xlen_t                  row_a[$];
    xlen_t                  row_b[$];
    logic [TID_W-1:0]       row_id[$];
    xlen_t                  row_exp[$];

    int unsigned            issue_cyc[$];   // Cycle at which each row was issued
    int unsigned            cycle_cnt = 0;
    int                     n_checks  = 0;
    int                     n_errors  = 0;
    bit                     timed_out = 1'b0; // Set once a row never returned

    pau_top #(
        .TRANS_ID_BITS ( TID_W )
    ) pau_top_inst (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .valid_i     ( valid_i     ),
        .op_i        ( op_i        ),
        .trans_id_i  ( trans_id_i  ),
        .operand_a_i ( operand_a_i ),
        .operand_b_i ( operand_b_i ),
        .valid_o     ( valid_o     ),
        .trans_id_o  ( trans_id_o  ),
        .result_o    ( result_o    )
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    task automatic add_row(input string name, input pau_op_e op, input xlen_t a,
                           input xlen_t b, input logic [TID_W-1:0] id,
                           input xlen_t expected);
        row_name.push_back(name);
        row_op.push_back(op);
        row_a.push_back(a);
        row_b.push_back(b);
        row_id.push_back(id);
        row_exp.push_back(expected);
    endtask

    task automatic finish_run();
        $display("Run complete: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // Waits on falling edges for the next valid_o
    task automatic wait_valid(input string name);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (!valid_o && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!valid_o) begin
            $display("Timeout: valid_o never rose for row %s", name);
            n_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_row(input int i);
        n_checks += 3;
        if (result_o !== row_exp[i]) begin
            $display("ERROR %s result: expected %h, actual %h",
                     row_name[i], row_exp[i], result_o);
            n_errors++;
        end
        if (trans_id_o !== row_id[i]) begin
            $display("ERROR %s trans_id: expected %h, actual %h",
                     row_name[i], row_id[i], trans_id_o);
            n_errors++;
        end
        if (cycle_cnt != issue_cyc[i] + 1) begin
            $display("ERROR %s latency: expected %0d, actual %0d",
                     row_name[i], 1, cycle_cnt - issue_cyc[i]);
            n_errors++;
        end
    endtask

    // One cycle after a lone result the output must be quiet again
    task automatic check_idle(input string name);
        @(negedge clk_i);
        n_checks += 2;
        if (valid_o !== 1'b0) begin
            $display("ERROR %s idle valid_o: expected %b, actual %b",
                     name, 1'b0, valid_o);
            n_errors++;
        end
        if (result_o !== '0) begin
            $display("ERROR %s idle result: expected %h, actual %h",
                     name, 64'h0, result_o);
            n_errors++;
        end
    endtask

    task automatic run_table(input int gap);
        fork
            begin : drive_rows
                for (int i = 0; i < row_name.size(); i++) begin
                    @(posedge clk_i);
                    #1;
                    valid_i     = 1'b1;
                    op_i        = row_op[i];
                    operand_a_i = row_a[i];
                    operand_b_i = row_b[i];
                    trans_id_i  = row_id[i];
                    issue_cyc.push_back(cycle_cnt);
                    for (int g = 0; g < gap; g++) begin
                        @(posedge clk_i);
                        #1;
                        valid_i = 1'b0;
                    end
                end
                @(posedge clk_i);
                #1;
                valid_i = 1'b0;
            end
            begin : check_rows
                for (int i = 0; i < row_name.size() && !timed_out; i++) begin
                    wait_valid(row_name[i]);
                    if (!timed_out) begin
                        check_row(i);
                        if (gap > 0 || i == row_name.size() - 1) begin
                            check_idle(row_name[i]);
                        end
                    end
                end
            end
        join
        issue_cyc.delete();
    endtask

    initial begin
        rst_ni      = 1'b0;
        valid_i     = 1'b0;
        op_i        = PSGNJ;
        trans_id_i  = '0;
        operand_a_i = '0;
        operand_b_i = '0;

        // Sign injection flips a to its negated posit
        add_row("sgnj_pp",  PSGNJ,  A_POS, B_POS, 3'd0, R_POS);
        add_row("sgnj_pn",  PSGNJ,  A_POS, B_NEG, 3'd1, R_NEG);
        add_row("sgnj_np",  PSGNJ,  A_NEG, B_POS, 3'd2, R_POS);
        add_row("sgnj_nn",  PSGNJ,  A_NEG, B_NEG, 3'd3, R_NEG);
        add_row("sgnjn_pp", PSGNJN, A_POS, B_POS, 3'd4, R_NEG);
        add_row("sgnjn_pn", PSGNJN, A_POS, B_NEG, 3'd5, R_POS);
        add_row("sgnjn_np", PSGNJN, A_NEG, B_POS, 3'd6, R_NEG);
        add_row("sgnjn_nn", PSGNJN, A_NEG, B_NEG, 3'd7, R_POS);
        add_row("sgnjx_pp", PSGNJX, A_POS, B_POS, 3'd0, R_POS);
        add_row("sgnjx_pn", PSGNJX, A_POS, B_NEG, 3'd1, R_NEG);
        add_row("sgnjx_np", PSGNJX, A_NEG, B_POS, 3'd2, R_NEG);
        add_row("sgnjx_nn", PSGNJX, A_NEG, B_NEG, 3'd3, R_POS);

        // Moves return the low word sign-extended
        add_row("x2p_neg", PMV_X2P, 64'h1234_5678_9ABC_DEF0, '0, 3'd4, 64'hFFFF_FFFF_9ABC_DEF0);
        add_row("x2p_pos", PMV_X2P, 64'hFEDC_BA98_7654_3210, '0, 3'd5, 64'h0000_0000_7654_3210);
        add_row("p2x_neg", PMV_P2X, 64'h1234_5678_9ABC_DEF0, '0, 3'd6, 64'hFFFF_FFFF_9ABC_DEF0);
        add_row("p2x_pos", PMV_P2X, 64'hFEDC_BA98_7654_3210, '0, 3'd7, 64'h0000_0000_7654_3210);

        // Posit to integer with ties to even
        add_row("p2i_one",    PCVT_P2I, 64'h4000_0000, '0, 3'd0, 64'd1);
        add_row("p2i_1p5",    PCVT_P2I, 64'h4400_0000, '0, 3'd1, 64'd2);
        add_row("p2i_2p5",    PCVT_P2I, 64'h4A00_0000, '0, 3'd2, 64'd2);
        add_row("p2i_m3",     PCVT_P2I, 64'hB400_0000, '0, 3'd3, 64'hFFFF_FFFF_FFFF_FFFD);
        add_row("p2i_half",   PCVT_P2I, 64'h3800_0000, '0, 3'd4, 64'd0);
        add_row("p2i_maxpos", PCVT_P2I, 64'h7FFF_FFFF, '0, 3'd5, 64'h0000_0000_7FFF_FFFF);
        add_row("p2i_minneg", PCVT_P2I, 64'h8000_0001, '0, 3'd6, 64'hFFFF_FFFF_8000_0000);
        add_row("p2i_nar",    PCVT_P2I, 64'h8000_0000, '0, 3'd7, 64'hFFFF_FFFF_8000_0000);
        add_row("p2i_zero",   PCVT_P2I, 64'h0,         '0, 3'd0, 64'd0);

        // Integer to posit where 2^31-1 rounds up into the next exponent
        add_row("i2p_zero",   PCVT_I2P, 64'h0,                   '0, 3'd1, 64'h0);
        add_row("i2p_one",    PCVT_I2P, 64'h1,                   '0, 3'd2, 64'h4000_0000);
        add_row("i2p_m1",     PCVT_I2P, 64'hFFFF_FFFF_FFFF_FFFF, '0, 3'd3, 64'hC000_0000);
        add_row("i2p_17",     PCVT_I2P, 64'd17,                  '0, 3'd4, 64'h6040_0000);
        add_row("i2p_rnd_up", PCVT_I2P, 64'h7FFF_FFFF,           '0, 3'd5, 64'h7FB0_0000);
        add_row("i2p_rnd_dn", PCVT_I2P, 64'h4000_0001,           '0, 3'd6, 64'h7FA0_0000);
        add_row("i2p_intmin", PCVT_I2P, 64'hFFFF_FFFF_8000_0000, '0, 3'd7, 64'h8050_0000);

        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        @(negedge clk_i);
        n_checks += 3;
        if (valid_o !== 1'b0) begin
            $display("ERROR reset valid_o: expected %b, actual %b", 1'b0, valid_o);
            n_errors++;
        end
        if (trans_id_o !== '0) begin
            $display("ERROR reset trans_id: expected %h, actual %h", 3'd0, trans_id_o);
            n_errors++;
        end
        if (result_o !== '0) begin
            $display("ERROR reset result: expected %h, actual %h", 64'h0, result_o);
            n_errors++;
        end

        run_table(1);   // One idle cycle after each row
        if (!timed_out) begin
            run_table(0);   // Back to back
        end

        finish_run();
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/posit_pkg.sv
src/pau_op_pkg.sv
src/pau_sign_move.sv
src/pau_convert.sv
src/pau_result.sv
src/pau_top.sv
testbench/tb_pau_top.sv
